// File: compile.f
+incdir+source
source/jag_periph_pkg.sv
source/ee_cmd_if.sv
source/ee_serial_ctrl.sv
source/ee_cell_array.sv
source/i2s_audio_rx.sv
source/jag_periph_top.sv
sim/jag_periph_sva.sv
sim/jag_periph_tb.sv

// File: sim/jag_periph_sva.sv
// Bound checks on EEPROM DO, sequencer busy length and audio sample update timing
`timescale 1ns/10ps
`include "jag_periph_macros.svh"

module jag_periph_sva (
	input logic              sys_clk,
	input logic              xresetl,
	input logic              ee_cs_i,
	input logic              ee_do_o,
	input logic              busy,       // Cell array sequencer running
	input logic              aud_next,   // Receiver word boundary flag
	input logic [`AUD_W-1:0] aud_l_o,
	input logic [`AUD_W-1:0] aud_r_o
);
	int fail_cnt = 0;                    // Assertion failures so far

	// Deselect forces ready on DO
	do_high_on_deselect: assert property (@(posedge sys_clk) disable iff (!xresetl)
		!ee_cs_i && !busy |=> ee_do_o)
		else begin
			$error("DO not high one cycle after CS went low");
			fail_cnt++;
		end

	// ERAL and WRAL are the longest runs
	busy_bounded: assert property (@(posedge sys_clk) disable iff (!xresetl)
		$rose(busy) |-> ##[1:130] !busy)
		else begin
			$error("EEPROM busy lasted longer than 130 cycles");
			fail_cnt++;
		end

	// Samples move only on the commit cycle
	aud_on_ws_change: assert property (@(posedge sys_clk) disable iff (!xresetl)
		!$stable({aud_l_o, aud_r_o}) |-> $past(aud_next))
		else begin
			$error("Audio output changed without a WS change");
			fail_cnt++;
		end

endmodule

bind jag_periph_top jag_periph_sva u_sva (
	.sys_clk  (sys_clk),
	.xresetl  (xresetl),
	.ee_cs_i  (ee_cs_i),
	.ee_do_o  (ee_do_o),
	.busy     (ee_cmd.busy),
	.aud_next (u_i2s_rx.next_q),
	.aud_l_o  (aud_l_o),
	.aud_r_o  (aud_r_o)
);

// File: sim/jag_periph_tb.sv
// Testbench for the peripheral serial block with EEPROM and I2S reference models
`timescale 1ns/10ps
`include "jag_periph_macros.svh"

module jag_periph_tb;
	localparam int CLK_NS    = 20;
	localparam int BIT_CYC   = 8;            // SK and SCK half period is 4 clocks
	localparam int READY_CYC = 200;          // Longest wait for DO ready
	localparam int EE_XFERS  = 80;           // Upper bound on EEPROM transactions
	localparam int EE_CYC    = 25 * BIT_CYC + 140;
	localparam int I2S_CYC   = 60 * 20 * BIT_CYC;
	localparam int WATCHDOG_NS = CLK_NS * (EE_XFERS * EE_CYC + I2S_CYC + 5000);

	logic              sys_clk;
	logic              xresetl;
	logic              ee_cs, ee_sk, ee_di;
	logic              i2s_sck, i2s_ws, i2s_sd;
	wire               ee_do;
	wire  [`AUD_W-1:0] aud_l, aud_r;

	logic [`EE_DATA_W-1:0] ee_model [`EE_DEPTH];   // Expected EEPROM contents
	logic                  ee_latch;               // Expected write-enable state
	logic [`AUD_W-1:0]     exp_l, exp_r;
	logic [31:0]           lfsr_q;
	int                    check_errs;
	int                    timeout_errs;

	jag_periph_top UUT (
		.sys_clk   (sys_clk),
		.xresetl   (xresetl),
		.ee_cs_i   (ee_cs),
		.ee_sk_i   (ee_sk),
		.ee_di_i   (ee_di),
		.ee_do_o   (ee_do),
		.i2s_sck_i (i2s_sck),
		.i2s_ws_i  (i2s_ws),
		.i2s_sd_i  (i2s_sd),
		.aud_l_o   (aud_l),
		.aud_r_o   (aud_r)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};   // One step per bit
		end
	endtask

	task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
		assert (got === exp) else begin
			check_errs++;
			$display("CHECK FAILED at %0d ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// One SK period with DI set up while SK is low
	task automatic clock_bit(input logic b);
		ee_di = b;
		ee_sk = 1'b0;
		repeat (4) @(negedge sys_clk);
		ee_sk = 1'b1;
		repeat (4) @(negedge sys_clk);
	endtask

	task automatic deselect_ee();
		ee_cs = 1'b0;
		ee_sk = 1'b0;
		ee_di = 1'b0;
		repeat (2) @(negedge sys_clk);
		check_eq(16'(ee_do), 16'h1, "DO high while CS low");
	endtask

	// Start bit, opcode, address
	task automatic send_instr(input logic [1:0] op, input logic [5:0] addr);
		logic [8:0] bits;
		bits  = {1'b1, op, addr};
		ee_cs = 1'b1;
		for (int i = 8; i >= 0; i--)
			clock_bit(bits[i]);
	endtask

	task automatic wait_ready(input string what);
		int n;
		n = 0;
		while (ee_do !== 1'b1 && n < READY_CYC) begin
			@(negedge sys_clk);
			n++;
		end
		if (ee_do !== 1'b1) begin
			timeout_errs++;
			$display("ERROR at %0d ns: DO never returned to ready after %s", $time, what);
		end
	endtask

	task automatic read_check(input logic [5:0] addr, input string what);
		logic [15:0] got;
		send_instr(jag_periph_pkg::READ, addr);
		check_eq(16'(ee_do), 16'h0, "READ dummy bit");
		for (int i = 15; i >= 0; i--) begin
			clock_bit(1'b0);
			got[i] = ee_do;                  // MSB first
		end
		deselect_ee();
		check_eq(got, ee_model[addr], what);
	endtask

	task automatic write_word(input logic [5:0] addr, input logic [15:0] data);
		send_instr(jag_periph_pkg::WRITE, addr);
		for (int i = 15; i >= 0; i--)
			clock_bit(data[i]);
		check_eq(16'(ee_do), 16'h0, "DO busy after WRITE");
		wait_ready("WRITE");
		deselect_ee();
		if (ee_latch)
			ee_model[addr] = data;
	endtask

	task automatic erase_word(input logic [5:0] addr);
		send_instr(jag_periph_pkg::ERASE, addr);
		check_eq(16'(ee_do), 16'h0, "DO busy after ERASE");
		wait_ready("ERASE");
		deselect_ee();
		if (ee_latch)
			ee_model[addr] = '1;
	endtask

	// EWEN, EWDS, ERAL, WRAL
	task automatic ext_cmd(input logic [1:0] ext, input logic [15:0] data);
		send_instr(jag_periph_pkg::EXT, {ext, 4'b0});
		if (ext == jag_periph_pkg::WRAL || ext == jag_periph_pkg::ERAL) begin
			if (ext == jag_periph_pkg::WRAL) begin
				for (int i = 15; i >= 0; i--)
					clock_bit(data[i]);
			end else begin
				data = '1;                   // Erased value
			end
			check_eq(16'(ee_do), 16'h0, "DO busy after all-word command");
			wait_ready("all-word command");
			if (ee_latch) begin
				for (int a = 0; a < `EE_DEPTH; a++)
					ee_model[a] = data;
			end
		end else begin
			ee_latch = (ext == jag_periph_pkg::EWEN);
		end
		deselect_ee();
	endtask

	// I2S word whose last bit goes out with the next word's WS
	task automatic i2s_word(input logic ws_word, input int nbits);
		logic [31:0]       r;
		logic [`AUD_W-1:0] word;
		word = '0;
		for (int i = 0; i < nbits; i++) begin
			rand_bits(1, r);
			if (i < `AUD_W)
				word[`AUD_W-1-i] = r[0];
			i2s_sd  = r[0];
			i2s_ws  = (i == nbits - 1) ? ~ws_word : ws_word;
			i2s_sck = 1'b0;
			repeat (4) @(negedge sys_clk);
			i2s_sck = 1'b1;
			repeat (4) @(negedge sys_clk);
		end
		if (!ws_word)
			exp_l = word;                    // WS low word is left
		else
			exp_r = word;
		check_eq(aud_l, exp_l, "left sample");
		check_eq(aud_r, exp_r, "right sample");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired before the tests finished");
		$display("Errors: %0d value checks, %0d timeouts, %0d assertion failures",
			check_errs, timeout_errs, UUT.u_sva.fail_cnt);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [5:0]  wa [20];
		logic [5:0]  tmp;
		int          j;
		xresetl = 1'b0;
		ee_cs   = 1'b0;
		ee_sk   = 1'b0;
		ee_di   = 1'b0;
		i2s_sck = 1'b0;
		i2s_ws  = 1'b0;
		i2s_sd  = 1'b0;
		lfsr_q  = 32'h7f5d_eeea;
		ee_latch     = 1'b0;
		exp_l        = '0;
		exp_r        = '0;
		check_errs   = 0;
		timeout_errs = 0;
		repeat (2) @(negedge sys_clk);
		xresetl = 1'b1;
		repeat (2) @(negedge sys_clk);
		check_eq(16'(ee_do), 16'h1, "DO high after reset");

		// Erase all then spot reads
		ext_cmd(jag_periph_pkg::EWEN, '0);
		ext_cmd(jag_periph_pkg::ERAL, '0);
		repeat (8) begin
			rand_bits(6, r);
			read_check(r[5:0], "read after ERAL");
		end

		// Random writes read back in shuffled order
		ext_cmd(jag_periph_pkg::EWEN, '0);
		for (int i = 0; i < 20; i++) begin
			rand_bits(6, r);
			rand_bits(16, d);
			wa[i] = r[5:0];
			write_word(r[5:0], d[15:0]);
		end
		for (int i = 19; i > 0; i--) begin
			rand_bits(5, r);
			j     = r % (i + 1);
			tmp   = wa[i];
			wa[i] = wa[j];
			wa[j] = tmp;
		end
		for (int i = 0; i < 20; i++)
			read_check(wa[i], "read after WRITE");

		// Memory must not move while write protected
		ext_cmd(jag_periph_pkg::EWDS, '0);
		rand_bits(6, r);
		rand_bits(16, d);
		write_word(r[5:0], d[15:0]);
		read_check(r[5:0], "read after protected WRITE");
		erase_word(wa[0]);                   // Holds written data, not the erased value
		read_check(wa[0], "read after protected ERASE");

		// WRAL then one ERASE checked against its neighbours
		ext_cmd(jag_periph_pkg::EWEN, '0);
		rand_bits(16, d);
		ext_cmd(jag_periph_pkg::WRAL, d[15:0]);
		repeat (8) begin
			rand_bits(6, r);
			read_check(r[5:0], "read after WRAL");
		end
		rand_bits(6, r);
		tmp = 6'(1 + r % 62);
		erase_word(tmp);
		read_check(tmp - 6'd1, "lower neighbour of ERASE");
		read_check(tmp, "erased word");
		read_check(tmp + 6'd1, "upper neighbour of ERASE");

		// Abort mid instruction
		ee_cs = 1'b1;
		clock_bit(1'b1);
		clock_bit(1'b1);
		clock_bit(1'b0);
		clock_bit(1'b1);
		deselect_ee();
		rand_bits(6, r);
		read_check(r[5:0], "read after CS abort");

		// Audio frames with left then right words
		for (int f = 0; f < 30; f++) begin
			rand_bits(3, r);
			i2s_word(1'b0, 16 + r % 5);
			rand_bits(3, r);
			i2s_word(1'b1, 16 + r % 5);
		end
		repeat (4) @(negedge sys_clk);

		$display("Errors: %0d value checks, %0d timeouts, %0d assertion failures",
			check_errs, timeout_errs, UUT.u_sva.fail_cnt);
		if (check_errs == 0 && timeout_errs == 0 && UUT.u_sva.fail_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: source/ee_cell_array.sv
// EEPROM storage with write-enable latch and the erase/write/loop sequencer
`timescale 1ns/10ps
`include "jag_periph_macros.svh"

module ee_cell_array (
	input logic     sys_clk,
	input logic     xresetl,
	ee_cmd_if.array cmd
);
	typedef enum logic [1:0] {
		SEQ_BEGIN,                       // Strobe taken
		SEQ_WRITE,                       // Cell update, gated by latch
		SEQ_LOOP,                        // Next address or finish
		SEQ_END                          // Resting, ready for a strobe
	} seq_state_e;

	logic [`EE_DATA_W-1:0] mem [`EE_DEPTH];
	logic                  ewen_q;       // Write-enable latch
	seq_state_e            seq_q;
	logic [`EE_ADDR_W-1:0] wr_addr_q;
	logic [`EE_DATA_W-1:0] wr_data_q;
	logic                  wr_loop_q;    // All-word form
	logic                  is_ext;
	logic                  is_all;
	logic                  is_erase;
	logic                  is_wr_cmd;
	logic                  start;

	assign is_ext    = cmd.instr.a.op == jag_periph_pkg::EXT;
	assign is_all    = is_ext && (cmd.instr.x.ext == jag_periph_pkg::ERAL ||
		cmd.instr.x.ext == jag_periph_pkg::WRAL);
	assign is_erase  = cmd.instr.a.op == jag_periph_pkg::ERASE ||
		(is_ext && cmd.instr.x.ext == jag_periph_pkg::ERAL);
	assign is_wr_cmd = is_all || cmd.instr.a.op == jag_periph_pkg::WRITE ||
		cmd.instr.a.op == jag_periph_pkg::ERASE;
	assign start     = seq_q == SEQ_END && cmd.cmd_stb && is_wr_cmd;

	assign cmd.busy    = seq_q != SEQ_END;
	assign cmd.rd_data = mem[cmd.rd_addr];

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			seq_q  <= SEQ_END;
			ewen_q <= 1'b0;              // Power up write-protected
		end else begin
			case (seq_q)
				SEQ_END: begin
					if (start)
						seq_q <= SEQ_BEGIN;
					else if (cmd.cmd_stb && is_ext && cmd.instr.x.ext == jag_periph_pkg::EWEN)
						ewen_q <= 1'b1;
					else if (cmd.cmd_stb && is_ext && cmd.instr.x.ext == jag_periph_pkg::EWDS)
						ewen_q <= 1'b0;
				end
				SEQ_BEGIN: seq_q <= SEQ_WRITE;
				SEQ_WRITE: seq_q <= SEQ_LOOP;
				SEQ_LOOP: begin
					if (!wr_loop_q || wr_addr_q == `EE_ADDR_W'(`EE_DEPTH - 1))
						seq_q <= SEQ_END;
					else
						seq_q <= SEQ_WRITE;
				end
				default: seq_q <= SEQ_END;
			endcase
		end
	end

	// Address, data and mode come from the strobed command
	always_ff @(posedge sys_clk) begin
		if (start) begin
			wr_addr_q <= is_all ? '0 : cmd.instr.a.addr;
			wr_data_q <= is_erase ? `EE_ERASED : cmd.wr_data;
			wr_loop_q <= is_all;
		end else if (seq_q == SEQ_LOOP && wr_loop_q) begin
			wr_addr_q <= wr_addr_q + 1'b1;   // Sweep 0 to 63
		end
		if (seq_q == SEQ_WRITE && ewen_q)
			mem[wr_addr_q] <= wr_data_q;     // Disabled latch runs the sequence dry
	end

endmodule

// File: source/ee_cmd_if.sv
// Command and read channel between the EEPROM serial front end and its cell array
`timescale 1ns/10ps
`include "jag_periph_macros.svh"

interface ee_cmd_if;
	logic                      cmd_stb;  // One cycle, instr and wr_data valid
	jag_periph_pkg::ee_instr_u instr;
	logic [`EE_DATA_W-1:0]     wr_data;  // Shifted-in word for WRITE and WRAL
	logic [`EE_ADDR_W-1:0]     rd_addr;
	logic [`EE_DATA_W-1:0]     rd_data;  // Async read of rd_addr
	logic                      busy;     // Write sequencer running

	// Serial side
	modport ctrl (
		output cmd_stb, instr, wr_data, rd_addr,
		input  rd_data, busy
	);

	// Storage side
	modport array (
		input  cmd_stb, instr, wr_data, rd_addr,
		output rd_data, busy
	);
endinterface

// File: source/ee_serial_ctrl.sv
// EEPROM serial front end that decodes SK/DI instructions, shifts data and drives DO
`timescale 1ns/10ps
`include "jag_periph_macros.svh"

module ee_serial_ctrl (
	input  logic   sys_clk,
	input  logic   xresetl,
	input  logic   cs_i,
	input  logic   sk_i,
	input  logic   di_i,
	output logic   do_o,
	ee_cmd_if.ctrl cmd
);
	localparam int CNT_W = $clog2(`EE_DATA_W);

	typedef enum logic [2:0] {
		ST_IDLE,                         // Hunting for start bit and opcode
		ST_DATA,                         // Shifting write data in
		ST_READ,                         // Shifting read data out
		ST_WSTART,                       // Strobe sent, pull DO low
		ST_WBUSY                         // Hold DO low until array is done
	} ctrl_state_e;

	ctrl_state_e               state_q;
	logic                      sk_prev_q;
	logic                      sk_rise;
	logic [7:0]                ir_sh_q;   // Start bit climbs to bit 7
	jag_periph_pkg::ee_instr_u instr_nxt; // Instruction as it completes
	jag_periph_pkg::ee_instr_u instr_q;
	logic [`EE_DATA_W-1:0]     dr_q;      // Shared in/out data shifter
	logic [CNT_W-1:0]          cnt_q;     // Data bits taken
	logic                      do_q;
	logic                      stb_q;

	assign sk_rise   = sk_i & ~sk_prev_q;
	assign instr_nxt = {ir_sh_q[6:0], di_i};

	// Address is live on the last SK so the read lands on that same edge
	assign cmd.rd_addr = instr_nxt.a.addr;
	assign cmd.instr   = instr_q;
	assign cmd.wr_data = dr_q;
	assign cmd.cmd_stb = stb_q;
	assign do_o        = do_q;

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			sk_prev_q <= 1'b0;
		end else begin
			sk_prev_q <= sk_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!xresetl || !cs_i) begin
			// Deselect drops back to idle, sequencer keeps running
			state_q <= ST_IDLE;
			ir_sh_q <= '0;
			cnt_q   <= '0;
			do_q    <= 1'b1;
			stb_q   <= 1'b0;
		end else begin
			stb_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (sk_rise && !cmd.busy) begin
						ir_sh_q <= {ir_sh_q[6:0], di_i};
						if (ir_sh_q[7]) begin  // Eighth bit after start
							ir_sh_q <= '0;
							instr_q <= instr_nxt;
							cnt_q   <= '0;
							case (instr_nxt.a.op)
								jag_periph_pkg::READ: begin
									dr_q    <= cmd.rd_data;
									do_q    <= 1'b0;  // Dummy zero
									state_q <= ST_READ;
								end
								jag_periph_pkg::WRITE: state_q <= ST_DATA;
								jag_periph_pkg::ERASE: begin
									stb_q   <= 1'b1;
									state_q <= ST_WSTART;
								end
								default: begin
									// EWEN and EWDS strobe and stay idle
									if (instr_nxt.x.ext == jag_periph_pkg::WRAL) begin
										state_q <= ST_DATA;
									end else begin
										stb_q <= 1'b1;
										if (instr_nxt.x.ext == jag_periph_pkg::ERAL)
											state_q <= ST_WSTART;
									end
								end
							endcase
						end
					end
				end
				ST_DATA: begin
					if (sk_rise) begin
						dr_q  <= {dr_q[`EE_DATA_W-2:0], di_i};  // MSB first
						cnt_q <= cnt_q + 1'b1;
						if (cnt_q == CNT_W'(`EE_DATA_W - 1)) begin
							stb_q   <= 1'b1;
							state_q <= ST_WSTART;
						end
					end
				end
				ST_READ: begin
					if (sk_rise) begin
						do_q <= dr_q[`EE_DATA_W-1];
						dr_q <= {dr_q[`EE_DATA_W-2:0], 1'b0};  // Zeros past the word
					end
				end
				ST_WSTART: begin
					do_q    <= 1'b0;             // Busy on DO
					state_q <= ST_WBUSY;
				end
				ST_WBUSY: begin
					if (!cmd.busy) begin
						do_q    <= 1'b1;         // Ready
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: source/i2s_audio_rx.sv
// I2S receiver that assembles 16-bit words and latches them as left or right samples
`timescale 1ns/10ps
`include "jag_periph_macros.svh"

module i2s_audio_rx (
	input  logic              sys_clk,
	input  logic              xresetl,
	input  logic              sck_i,
	input  logic              ws_i,
	input  logic              sd_i,
	output logic [`AUD_W-1:0] aud_l_o,
	output logic [`AUD_W-1:0] aud_r_o
);
	logic                  sck_prev_q;
	logic                  sck_rise;
	logic                  ws_prev_q;    // WS as of the last SCK rise
	logic                  next_q;       // Word boundary seen
	logic [`AUD_CNT_W-1:0] cnt_q;        // Bits taken, top bit = full
	logic [`AUD_W-1:0]     buf_q;

	assign sck_rise = sck_i & ~sck_prev_q;

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			sck_prev_q <= 1'b0;
			ws_prev_q  <= 1'b0;
			next_q     <= 1'b0;
			cnt_q      <= '0;
			buf_q      <= '0;
			aud_l_o    <= '0;
			aud_r_o    <= '0;
		end else begin
			sck_prev_q <= sck_i;
			if (sck_rise) begin
				// Extra bits past 16 are dropped
				if (!cnt_q[`AUD_CNT_W-1]) begin
					cnt_q <= cnt_q + 1'b1;
					buf_q[~cnt_q[`AUD_CNT_W-2:0]] <= sd_i;  // MSB first
				end
				ws_prev_q <= ws_i;
				if (ws_prev_q != ws_i)
					next_q <= 1'b1;      // WS leads the new word by one SCK
			end
			// Commit one cycle after the change, overrides a same-cycle bit
			if (next_q) begin
				next_q <= 1'b0;
				cnt_q  <= '0;
				buf_q  <= '0;
				if (ws_prev_q)
					aud_l_o <= buf_q;
				else
					aud_r_o <= buf_q;
			end
		end
	end

endmodule

// File: source/jag_periph_macros.svh
// Peripheral serial block constants for EEPROM geometry and I2S sample widths
`ifndef JAG_PERIPH_MACROS_SVH
`define JAG_PERIPH_MACROS_SVH

// 93C46 style serial EEPROM in 64 x 16 organisation
`define EE_ADDR_W 6                      // Word address bits
`define EE_DATA_W 16                     // Word width
`define EE_DEPTH  64                     // Words in the array

// Value left behind by ERASE and ERAL
`define EE_ERASED {`EE_DATA_W{1'b1}}

// I2S receiver
`define AUD_W     16                     // Sample width, MSB first on the wire
`define AUD_CNT_W 5                      // Bit counter, top bit flags a full word

`endif

// File: source/jag_periph_pkg.sv
// Types shared by the EEPROM halves: opcodes and the instruction word union
`include "jag_periph_macros.svh"

package jag_periph_pkg;

	// Two bits right after the start bit
	typedef enum logic [1:0] {
		EXT   = 2'b00,                   // Extended, sub-op in the address field
		WRITE = 2'b01,
		READ  = 2'b10,
		ERASE = 2'b11
	} ee_op_e;

	// Top two address bits when the primary opcode is EXT
	typedef enum logic [1:0] {
		EWDS = 2'b00,                    // Write disable
		WRAL = 2'b01,                    // Write all words
		ERAL = 2'b10,                    // Erase all words
		EWEN = 2'b11                     // Write enable
	} ee_ext_e;

	// Opcode plus word address
	typedef struct packed {
		ee_op_e                op;
		logic [`EE_ADDR_W-1:0] addr;
	} ee_addr_view_s;

	// Opcode plus extended opcode, low address bits are don't care
	typedef struct packed {
		ee_op_e                  op;
		ee_ext_e                 ext;
		logic [`EE_ADDR_W-3:0]   unused;
	} ee_ext_view_s;

	// The 8 bits after the start bit, read either way depending on op
	typedef union packed {
		ee_addr_view_s a;
		ee_ext_view_s  x;
	} ee_instr_u;

endpackage

// File: source/jag_periph_top.sv
// Peripheral serial block top with the 93C46 EEPROM and the I2S audio receiver
`timescale 1ns/10ps
`include "jag_periph_macros.svh"

module jag_periph_top (
	input  logic              sys_clk,
	input  logic              xresetl,
	input  logic              ee_cs_i,
	input  logic              ee_sk_i,
	input  logic              ee_di_i,
	output logic              ee_do_o,
	input  logic              i2s_sck_i,
	input  logic              i2s_ws_i,
	input  logic              i2s_sd_i,
	output logic [`AUD_W-1:0] aud_l_o,
	output logic [`AUD_W-1:0] aud_r_o
);
	// Strobe, instruction, data and read port between the EEPROM halves
	ee_cmd_if ee_cmd ();

	ee_serial_ctrl u_ee_ctrl (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.cs_i    (ee_cs_i),
		.sk_i    (ee_sk_i),
		.di_i    (ee_di_i),
		.do_o    (ee_do_o),
		.cmd     (ee_cmd.ctrl)
	);

	ee_cell_array u_ee_array (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.cmd     (ee_cmd.array)
	);

	// Audio path is independent of the EEPROM
	i2s_audio_rx u_i2s_rx (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.sck_i   (i2s_sck_i),
		.ws_i    (i2s_ws_i),
		.sd_i    (i2s_sd_i),
		.aud_l_o (aud_l_o),
		.aud_r_o (aud_r_o)
	);

endmodule
